// File: dv/clint_chk.sv
`default_nettype none

module clint_chk (
    input  wire logic                         clk,
    input  wire logic                         rst_n,
    input  wire logic                         wb_cyc_i,
    input  wire logic                         wb_stb_i,
    input  wire logic                         wb_we_i,
    input  wire logic [clint_pkg::ADDR_W-1:0] wb_adr_i,
    input  wire logic                         wb_ack_o,
    input  wire logic                         software_int_o,
    input  wire logic                         timer_int_o
);

    import clint_pkg::*;

    logic msip_write;

    assign msip_write = wb_cyc_i && wb_stb_i && wb_we_i && (wb_adr_i == MSIP);

    // Zero wait state slave
    ack_follows_request: assert property (
        @(posedge clk) disable iff (!rst_n) wb_ack_o == (wb_cyc_i && wb_stb_i)
    ) else $error("wb_ack_o differs from cyc and stb");

    irq_low_in_reset: assert property (
        @(posedge clk) !rst_n |-> (software_int_o == 1'b0 && timer_int_o == 1'b0)
    ) else $error("interrupt active while reset is asserted");

    // msip only moves after a write to its offset
    soft_irq_stable: assert property (
        @(posedge clk) disable iff (!rst_n) !$past(msip_write) |-> $stable(software_int_o)
    ) else $error("software_int_o changed without an MSIP write");

endmodule

bind clint_top clint_chk u_chk (
    .clk            (clk),
    .rst_n          (rst_n),
    .wb_cyc_i       (wb_cyc_i),
    .wb_stb_i       (wb_stb_i),
    .wb_we_i        (wb_we_i),
    .wb_adr_i       (wb_adr_i),
    .wb_ack_o       (wb_ack_o),
    .software_int_o (software_int_o),
    .timer_int_o    (timer_int_o)
);

`default_nettype wire

// File: dv/tb_clint.sv
`default_nettype none

module tb_clint;

    import clint_pkg::*;

    localparam int unsigned TICK_DIV    = 4;
    localparam int unsigned TICKS_APART = 16;
    localparam int unsigned IRQ_DELTA   = 5;

    logic              clk;
    logic              rst_n;
    logic              wb_cyc;
    logic              wb_stb;
    logic              wb_we;
    logic [ADDR_W-1:0] wb_adr;
    logic [SEL_W-1:0]  wb_sel;
    logic [DATA_W-1:0] wb_dat_w;
    logic [DATA_W-1:0] wb_dat_r;
    logic              wb_ack;
    logic              software_int;
    logic              timer_int;
    int unsigned       seed_val;

    clint_top #(
        .TICK_DIV (TICK_DIV)
    ) DUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .wb_cyc_i       (wb_cyc),
        .wb_stb_i       (wb_stb),
        .wb_we_i        (wb_we),
        .wb_adr_i       (wb_adr),
        .wb_sel_i       (wb_sel),
        .wb_dat_i       (wb_dat_w),
        .wb_dat_o       (wb_dat_r),
        .wb_ack_o       (wb_ack),
        .software_int_o (software_int),
        .timer_int_o    (timer_int)
    );

    always #10 clk = ~clk;

    task automatic abort_run();
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [DATA_W-1:0] exp,
                              input logic [DATA_W-1:0] got);
        if (got !== exp) begin
            $display("FAILED at %0t: %s expected %h actual %h", $time, name, exp, got);
            abort_run();
        end
    endtask

    task automatic check_time(input string name, input mtime_t exp, input mtime_t got);
        if (got !== exp) begin
            $display("FAILED at %0t: %s expected %h actual %h", $time, name, exp, got);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            $display("FAILED at %0t: %s expected %b actual %b", $time, name, exp, got);
            abort_run();
        end
    endtask

    // One request cycle, ack is checked mid cycle
    task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [SEL_W-1:0] sel,
                             input logic [DATA_W-1:0] data);
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= 1'b1;
        wb_adr   <= addr;
        wb_sel   <= sel;
        wb_dat_w <= data;
        @(negedge clk);
        check_bit("wb_ack_o", 1'b1, wb_ack);
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic bus_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= 1'b0;
        wb_adr <= addr;
        wb_sel <= '1;
        @(negedge clk);
        check_bit("wb_ack_o", 1'b1, wb_ack);
        data = wb_dat_r;
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
    endtask

    task automatic read_time(output mtime_t value);
        logic [DATA_W-1:0] lo;
        logic [DATA_W-1:0] hi;
        bus_read(MTIME, lo);
        bus_read(MTIMEH, hi);
        value = {hi, lo};
    endtask

    function automatic logic [DATA_W-1:0] merge_lanes(input logic [DATA_W-1:0] old_w,
                                                      input logic [DATA_W-1:0] new_w,
                                                      input logic [SEL_W-1:0]  sel);
        logic [DATA_W-1:0] res;
        res = old_w;
        for (int i = 0; i < SEL_W; i++) begin
            if (sel[i]) begin
                res[8*i +: 8] = new_w[8*i +: 8];
            end
        end
        return res;
    endfunction

    function automatic logic is_mapped(input logic [ADDR_W-1:0] addr);
        return addr == MSIP || addr == MTIME || addr == MTIMEH ||
               addr == MTIMECMP || addr == MTIMECMPH;
    endfunction

    task automatic test_reset();
        logic [DATA_W-1:0] data;
        @(negedge clk);
        check_bit("software_int_o", 1'b0, software_int);
        check_bit("timer_int_o", 1'b0, timer_int);
        bus_read(MSIP, data);
        check_word("msip", '0, data);
        bus_read(MTIMEH, data);
        check_word("mtimeh", '0, data);
        bus_read(MTIMECMP, data);
        check_word("mtimecmp", '1, data);
        bus_read(MTIMECMPH, data);
        check_word("mtimecmph", '1, data);
    endtask

    task automatic test_software_irq();
        logic [DATA_W-1:0] data;
        logic [DATA_W-1:0] word;
        bus_write(MSIP, '1, 32'h1);
        @(negedge clk);
        check_bit("software_int_o", 1'b1, software_int);
        bus_write(MSIP, '1, 32'h0);
        @(negedge clk);
        check_bit("software_int_o", 1'b0, software_int);
        word = $urandom;
        bus_write(MSIP, '1, word);
        bus_read(MSIP, data);
        check_word("msip", {31'b0, word[0]}, data);
        // Lane 0 disabled, msip must hold
        bus_write(MSIP, '1, 32'h1);
        bus_write(MSIP, 4'b1110, 32'h0);
        bus_read(MSIP, data);
        check_word("msip", 32'h1, data);
        @(negedge clk);
        check_bit("software_int_o", 1'b1, software_int);
        bus_write(MSIP, '1, 32'h0);
    endtask

    task automatic test_cmp_lanes();
        mtime_t            model;
        logic [DATA_W-1:0] data;
        logic [DATA_W-1:0] wdata;
        logic [SEL_W-1:0]  sel;
        model = '1;
        for (int n = 0; n < 8; n++) begin
            wdata = $urandom;
            sel   = $urandom;
            if ($urandom % 2) begin
                bus_write(MTIMECMPH, sel, wdata);
                model[2*DATA_W-1:DATA_W] = merge_lanes(model[2*DATA_W-1:DATA_W], wdata, sel);
            end else begin
                bus_write(MTIMECMP, sel, wdata);
                model[DATA_W-1:0] = merge_lanes(model[DATA_W-1:0], wdata, sel);
            end
            bus_read(MTIMECMP, data);
            check_word("mtimecmp", model[DATA_W-1:0], data);
            bus_read(MTIMECMPH, data);
            check_word("mtimecmph", model[2*DATA_W-1:DATA_W], data);
        end
        bus_write(MTIMECMP, '1, '1);
        bus_write(MTIMECMPH, '1, '1);
    endtask

    task automatic test_timer_rate();
        mtime_t            first;
        mtime_t            second;
        logic [DATA_W-1:0] lo_w;
        logic [DATA_W-1:0] data;
        logic [7:0]        byte_w;
        // Low word just short of the carry into mtimeh
        bus_write(MTIMEH, '1, $urandom & 32'h7FFF_FFFF);
        bus_write(MTIME, '1, 32'hFFFF_FFF0 | ($urandom % 8));
        read_time(first);
        repeat (TICKS_APART * TICK_DIV - 4) @(posedge clk);
        read_time(second);
        check_time("mtime", first + TICKS_APART, second);

        lo_w   = ($urandom & 32'hFFFF_FF00) | 32'h10;
        byte_w = $urandom;
        bus_write(MTIME, '1, lo_w);
        bus_write(MTIME, 4'b0010, {4{byte_w}});
        bus_read(MTIME, data);
        check_word("mtime upper bytes", {lo_w[31:16], byte_w, 8'h00}, data & 32'hFFFF_FF00);
        if (data[7:0] < 8'h10 || data[7:0] > 8'h13) begin
            $display("Byte 0 of mtime moved more than the elapsed ticks allow");
            abort_run();
        end
    endtask

    task automatic test_timer_irq();
        mtime_t      now;
        mtime_t      cmp;
        mtime_t      later;
        int unsigned waited;
        read_time(now);
        cmp = now + IRQ_DELTA;
        bus_write(MTIMECMP, '1, cmp[DATA_W-1:0]);
        bus_write(MTIMECMPH, '1, cmp[2*DATA_W-1:DATA_W]);
        @(negedge clk);
        check_bit("timer_int_o", 1'b0, timer_int);
        waited = 0;
        while (!timer_int && waited < (IRQ_DELTA + 2) * TICK_DIV) begin
            @(negedge clk);
            waited++;
        end
        if (!timer_int) begin
            $display("Timer interrupt did not rise before the timeout");
            abort_run();
        end
        read_time(later);
        if (later < cmp) begin
            $display("Timer interrupt rose while mtime was below the compare value");
            abort_run();
        end
        bus_write(MTIMECMPH, '1, later[2*DATA_W-1:DATA_W] + 1);
        @(negedge clk);
        check_bit("timer_int_o", 1'b0, timer_int);
    endtask

    task automatic test_unmapped();
        logic [DATA_W-1:0] msip_w;
        logic [DATA_W-1:0] cmp_lo;
        logic [DATA_W-1:0] cmp_hi;
        logic [DATA_W-1:0] time_hi;
        logic [DATA_W-1:0] time_lo;
        logic [DATA_W-1:0] data;
        logic [ADDR_W-1:0] addr;
        bus_write(MSIP, '1, 32'h1);
        bus_read(MSIP, msip_w);
        bus_read(MTIMECMP, cmp_lo);
        bus_read(MTIMECMPH, cmp_hi);
        bus_read(MTIMEH, time_hi);
        bus_read(MTIME, time_lo);
        for (int n = 0; n < 8; n++) begin
            addr = $urandom;
            // Bit 4 flipped moves any register offset off the map
            if (is_mapped(addr)) begin
                addr = addr ^ 16'h0010;
            end
            bus_write(addr, '1, $urandom);
            bus_read(addr, data);
            check_word("unmapped read", '0, data);
        end
        // About 34 cycles have passed, so only a few ticks
        bus_read(MTIME, data);
        if (data - time_lo > 16) begin
            $display("mtime low word jumped during writes to unmapped offsets");
            abort_run();
        end
        bus_read(MSIP, data);
        check_word("msip", msip_w, data);
        bus_read(MTIMECMP, data);
        check_word("mtimecmp", cmp_lo, data);
        bus_read(MTIMECMPH, data);
        check_word("mtimecmph", cmp_hi, data);
        bus_read(MTIMEH, data);
        check_word("mtimeh", time_hi, data);
    endtask

    initial begin
        seed_val = $urandom(37);
        clk      = 1'b0;
        rst_n    = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_sel   = '0;
        wb_dat_w = '0;
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        test_reset();
        test_software_irq();
        test_cmp_lanes();
        test_timer_rate();
        test_timer_irq();
        test_unmapped();

        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
hdl/clint_pkg.sv
hdl/mtime_counter.sv
hdl/clint_regs.sv
hdl/clint_top.sv
dv/clint_chk.sv
dv/tb_clint.sv

// File: hdl/clint_pkg.sv
`default_nettype none

package clint_pkg;

    // Bus geometry
    localparam int unsigned ADDR_W = 16;
    localparam int unsigned DATA_W = 32;
    localparam int unsigned SEL_W  = DATA_W / 8;

    // Register offsets within the 16-bit window
    typedef enum logic [ADDR_W-1:0] {
        MSIP      = 16'h0000,
        MTIME     = 16'h4000,
        MTIMEH    = 16'h4004,
        MTIMECMP  = 16'hBFF8,
        MTIMECMPH = 16'hBFFC
    } clint_addr_e;

    // Timer and compare values span two bus words
    typedef logic [2*DATA_W-1:0] mtime_t;

    // Compare starts at the top of the range so timer_int stays low
    localparam mtime_t MTIMECMP_RST = '1;

endpackage

`default_nettype wire

// File: hdl/clint_regs.sv
`default_nettype none

module clint_regs (
    input  wire logic                         clk,
    input  wire logic                         rst_n,

    input  wire logic                         wb_cyc_i,
    input  wire logic                         wb_stb_i,
    input  wire logic                         wb_we_i,
    input  wire logic [clint_pkg::ADDR_W-1:0] wb_adr_i,
    input  wire logic [clint_pkg::SEL_W-1:0]  wb_sel_i,
    input  wire logic [clint_pkg::DATA_W-1:0] wb_dat_i,
    output logic      [clint_pkg::DATA_W-1:0] wb_dat_o,
    output logic                              wb_ack_o,

    input  wire clint_pkg::mtime_t            mtime_i,
    output logic                              time_wr_lo_o,
    output logic                              time_wr_hi_o,
    output logic      [clint_pkg::SEL_W-1:0]  time_sel_o,
    output logic      [clint_pkg::DATA_W-1:0] time_dat_o,

    output logic                              software_int_o,
    output logic                              timer_int_o
);

    import clint_pkg::*;

    logic req;
    logic wr;

    logic hit_msip;
    logic hit_mtime;
    logic hit_mtimeh;
    logic hit_cmp_lo;
    logic hit_cmp_hi;

    logic   msip_q;
    logic   msip_d;
    mtime_t mtimecmp_q;
    mtime_t mtimecmp_d;

    // Single-cycle slave, no wait states
    assign req      = wb_cyc_i & wb_stb_i;
    assign wr       = req & wb_we_i;
    assign wb_ack_o = req;

    // Offset decode
    assign hit_msip   = (wb_adr_i == MSIP);
    assign hit_mtime  = (wb_adr_i == MTIME);
    assign hit_mtimeh = (wb_adr_i == MTIMEH);
    assign hit_cmp_lo = (wb_adr_i == MTIMECMP);
    assign hit_cmp_hi = (wb_adr_i == MTIMECMPH);

    // Timer writes are applied inside the counter
    assign time_wr_lo_o = wr & hit_mtime;
    assign time_wr_hi_o = wr & hit_mtimeh;
    assign time_sel_o   = wb_sel_i;
    assign time_dat_o   = wb_dat_i;

    // Only bit 0 of msip exists
    assign msip_d = (wr && hit_msip && wb_sel_i[0]) ? wb_dat_i[0] : msip_q;

    always_comb begin
        mtimecmp_d = mtimecmp_q;
        for (int i = 0; i < SEL_W; i++) begin
            if (wr && hit_cmp_lo && wb_sel_i[i]) begin
                mtimecmp_d[8*i +: 8] = wb_dat_i[8*i +: 8];
            end
            if (wr && hit_cmp_hi && wb_sel_i[i]) begin
                mtimecmp_d[DATA_W + 8*i +: 8] = wb_dat_i[8*i +: 8];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            msip_q     <= 1'b0;
            mtimecmp_q <= MTIMECMP_RST;
        end else begin
            msip_q     <= msip_d;
            mtimecmp_q <= mtimecmp_d;
        end
    end

    // Read mux, unmapped offsets return zero
    always_comb begin
        case (wb_adr_i)
            MSIP:      wb_dat_o = {{(DATA_W-1){1'b0}}, msip_q};
            MTIME:     wb_dat_o = mtime_i[DATA_W-1:0];
            MTIMEH:    wb_dat_o = mtime_i[2*DATA_W-1:DATA_W];
            MTIMECMP:  wb_dat_o = mtimecmp_q[DATA_W-1:0];
            MTIMECMPH: wb_dat_o = mtimecmp_q[2*DATA_W-1:DATA_W];
            default:   wb_dat_o = '0;
        endcase
    end

    // Interrupt levels
    assign software_int_o = msip_q;
    assign timer_int_o    = (mtime_i >= mtimecmp_q);

endmodule

`default_nettype wire

// File: hdl/clint_top.sv
`default_nettype none

module clint_top #(
    parameter int unsigned TICK_DIV = 1
) (
    input  wire logic                         clk,
    input  wire logic                         rst_n,

    input  wire logic                         wb_cyc_i,
    input  wire logic                         wb_stb_i,
    input  wire logic                         wb_we_i,
    input  wire logic [clint_pkg::ADDR_W-1:0] wb_adr_i,
    input  wire logic [clint_pkg::SEL_W-1:0]  wb_sel_i,
    input  wire logic [clint_pkg::DATA_W-1:0] wb_dat_i,
    output logic      [clint_pkg::DATA_W-1:0] wb_dat_o,
    output logic                              wb_ack_o,

    output logic                              software_int_o,
    output logic                              timer_int_o
);

    import clint_pkg::*;

    // Timer write path and timer value
    logic              time_wr_lo;
    logic              time_wr_hi;
    logic [SEL_W-1:0]  time_sel;
    logic [DATA_W-1:0] time_dat;
    mtime_t            mtime;

    clint_regs u_regs (
        .clk            (clk),
        .rst_n          (rst_n),
        .wb_cyc_i       (wb_cyc_i),
        .wb_stb_i       (wb_stb_i),
        .wb_we_i        (wb_we_i),
        .wb_adr_i       (wb_adr_i),
        .wb_sel_i       (wb_sel_i),
        .wb_dat_i       (wb_dat_i),
        .wb_dat_o       (wb_dat_o),
        .wb_ack_o       (wb_ack_o),
        .mtime_i        (mtime),
        .time_wr_lo_o   (time_wr_lo),
        .time_wr_hi_o   (time_wr_hi),
        .time_sel_o     (time_sel),
        .time_dat_o     (time_dat),
        .software_int_o (software_int_o),
        .timer_int_o    (timer_int_o)
    );

    mtime_counter #(
        .TICK_DIV (TICK_DIV)
    ) u_mtime (
        .clk          (clk),
        .rst_n        (rst_n),
        .time_wr_lo_i (time_wr_lo),
        .time_wr_hi_i (time_wr_hi),
        .time_sel_i   (time_sel),
        .time_dat_i   (time_dat),
        .mtime_o      (mtime)
    );

endmodule

`default_nettype wire

// File: hdl/mtime_counter.sv
`default_nettype none

module mtime_counter #(
    parameter int unsigned TICK_DIV = 1
) (
    input  wire logic                         clk,
    input  wire logic                         rst_n,
    input  wire logic                         time_wr_lo_i,
    input  wire logic                         time_wr_hi_i,
    input  wire logic [clint_pkg::SEL_W-1:0]  time_sel_i,
    input  wire logic [clint_pkg::DATA_W-1:0] time_dat_i,
    output clint_pkg::mtime_t                 mtime_o
);

    import clint_pkg::*;

    // A one-bit prescaler is kept for TICK_DIV of 1, it never leaves zero
    localparam int unsigned PRE_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
    localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(TICK_DIV - 1);

    logic [PRE_W-1:0] pre_q;
    logic [PRE_W-1:0] pre_d;
    logic             tick;

    mtime_t mtime_q;
    mtime_t mtime_d;

    // Prescaler wraps once every TICK_DIV cycles
    assign tick  = (pre_q == PRE_LAST);
    assign pre_d = tick ? '0 : pre_q + 1'b1;

    always_comb begin
        mtime_t inc;

        inc     = tick ? mtime_q + 1'b1 : mtime_q;
        mtime_d = inc;

        // Written lanes override the incremented value
        for (int i = 0; i < SEL_W; i++) begin
            if (time_wr_lo_i && time_sel_i[i]) begin
                mtime_d[8*i +: 8] = time_dat_i[8*i +: 8];
            end
            if (time_wr_hi_i && time_sel_i[i]) begin
                mtime_d[DATA_W + 8*i +: 8] = time_dat_i[8*i +: 8];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pre_q <= '0;
        end else begin
            pre_q <= pre_d;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtime_q <= '0;
        end else begin
            mtime_q <= mtime_d;
        end
    end

    assign mtime_o = mtime_q;

endmodule

`default_nettype wire
